// ==== src/ow_pkg.sv ====
`default_nettype none

package ow_pkg;

   // control word opcode, bits 1:0
   typedef enum logic [1:0] {
      ow_disable    = 2'd0,  // release the line
      ow_enable     = 2'd1,  // take the line
      ow_start_read = 2'd2,  // reset, rom, first block
      ow_continue   = 2'd3   // next block, no reset
   } ow_cmd_e;

   // transaction sequencer states
   typedef enum logic [2:0] {
      idle, reset, rom_cmd, rom_read, mem_cmd, addr_lo, addr_hi, mem_read
   } ow_state_e;

   // reset outcome, same coding as status bits 2:1
   typedef enum logic [1:0] {
      res_none, res_ok, res_fail_rise, res_fail_presence
   } ow_reset_res_e;

   // 1-wire timing in us, scaled by clk_mhz in the engines
   localparam int us_reset_low     = 480;
   localparam int us_rise_max      = 5;   // missing pull-up otherwise
   localparam int us_presence_wait = 30;
   localparam int us_presence_max  = 300;
   localparam int us_recover       = 500;
   localparam int us_w0_low        = 80;
   localparam int us_w1_low        = 8;
   localparam int us_wslot         = 90;  // slot plus recovery
   localparam int us_rd_low        = 1;
   localparam int us_rd_sample     = 15;
   localparam int us_rslot         = 121;

   // ds2505 command bytes
   localparam logic [7:0] cmd_read_rom  = 8'h33;
   localparam logic [7:0] cmd_read_mem  = 8'hF0;
   localparam logic [7:0] family_ds2505 = 8'h0B;

   localparam int rom_bytes = 8;
   localparam int blk_bytes = 256;
   localparam int blk_quads = 64;   // blk_bytes / 4

endpackage

`default_nettype wire

// ==== src/ow_byte_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one byte transfer, sequencer <-> bit-slot engine
interface ow_byte_if;
   logic       start;    // 1-cycle pulse, only when idle
   logic       wr;       // 1 = write tx_byte, 0 = read
   logic [7:0] tx_byte;
   logic       done;     // pulse after the eighth slot
   logic [7:0] rx_byte;  // valid with done

   modport master (output start, wr, tx_byte, input done, rx_byte);
   modport slave  (input start, wr, tx_byte, output done, rx_byte);
endinterface

`default_nettype wire

// ==== src/ow_reset_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// reset/presence handshake, sequencer <-> reset controller
interface ow_reset_if;
   import ow_pkg::*;

   logic          start;      // pulse
   logic          done;       // pulse at end of recovery or on failure
   ow_reset_res_e result;     // held until next start
   logic [7:0]    rise_time;  // clocks, saturating

   modport master (output start, input done, result, rise_time);
   modport slave  (input start, output done, result, rise_time);
endinterface

`default_nettype wire

// ==== src/ow_bit_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module ow_bit_engine #(
   parameter int clk_mhz = 49
) (
   input  wire       clk,
   input  wire       rst,
   input  wire       in,        // sampled bus line
   ow_byte_if.slave  bif,
   output logic      line_low   // pull request for the bus
);
   import ow_pkg::*;

   localparam int cnt_w = $clog2(us_rslot * clk_mhz);
   localparam logic [cnt_w-1:0] wslot_end = cnt_w'(us_wslot * clk_mhz - 1);
   localparam logic [cnt_w-1:0] rslot_end = cnt_w'(us_rslot * clk_mhz - 1);
   localparam logic [cnt_w-1:0] w0_low_n  = cnt_w'(us_w0_low * clk_mhz);
   localparam logic [cnt_w-1:0] w1_low_n  = cnt_w'(us_w1_low * clk_mhz);
   localparam logic [cnt_w-1:0] rd_low_n  = cnt_w'(us_rd_low * clk_mhz);
   localparam logic [cnt_w-1:0] rd_smp_n  = cnt_w'(us_rd_sample * clk_mhz);

   logic             busy_r;    // byte in progress
   logic             wr_r;      // direction latched at start
   logic [7:0]       shreg;     // tx bits out, rx bits in, lsb first
   logic [2:0]       bit_idx;   // current slot 0..7
   logic [cnt_w-1:0] cnt;       // clock inside slot
   logic [cnt_w-1:0] low_len;   // low time of this slot
   logic [cnt_w-1:0] slot_end;

   always_comb begin
      if (!wr_r)
         low_len = rd_low_n;         // short read pulse
      else if (shreg[bit_idx])
         low_len = w1_low_n;
      else
         low_len = w0_low_n;
      slot_end = wr_r ? wslot_end : rslot_end;
   end

   assign line_low    = busy_r && (cnt < low_len);  // low from slot start
   assign bif.rx_byte = shreg;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy_r   <= 1'b0;
         bif.done <= 1'b0;
         cnt      <= '0;
         bit_idx  <= 3'd0;
      end else begin
         bif.done <= 1'b0;
         if (bif.start && !busy_r) begin
            busy_r  <= 1'b1;
            wr_r    <= bif.wr;
            shreg   <= bif.tx_byte;
            cnt     <= '0;
            bit_idx <= 3'd0;
         end else if (busy_r) begin
            if (!wr_r && cnt == rd_smp_n)
               shreg[bit_idx] <= in;  // sample well after release
            if (cnt == slot_end) begin
               cnt     <= '0;
               bit_idx <= bit_idx + 3'd1;
               if (bit_idx == 3'd7) begin
                  busy_r   <= 1'b0;
                  bif.done <= 1'b1;   // one clock after last slot
               end
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      end
   end

   // sequencer must wait for done before the next byte
   assert property (@(posedge clk) disable iff (rst) bif.start |-> !busy_r)
      else $error("bit engine: start while a byte is in progress");

endmodule

`default_nettype wire

// ==== src/ow_reset_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module ow_reset_ctrl #(
   parameter int clk_mhz = 49
) (
   input  wire       clk,
   input  wire       rst,
   input  wire       in,        // sampled bus line
   ow_reset_if.slave rif,
   output logic      line_low
);
   import ow_pkg::*;

   typedef enum logic [2:0] {
      ph_idle, ph_low, ph_rise, ph_wait, ph_presence, ph_recover
   } phase_e;

   localparam int cnt_w = $clog2(us_recover * clk_mhz + 1);  // longest phase
   localparam logic [cnt_w-1:0] low_end  = cnt_w'(us_reset_low * clk_mhz - 1);
   localparam logic [cnt_w-1:0] rise_max = cnt_w'(us_rise_max * clk_mhz);
   localparam logic [cnt_w-1:0] wait_end = cnt_w'(us_presence_wait * clk_mhz - 1);
   localparam logic [cnt_w-1:0] pres_max = cnt_w'(us_presence_max * clk_mhz);
   localparam logic [cnt_w-1:0] rec_end  = cnt_w'(us_recover * clk_mhz - 1);

   phase_e           phase;
   logic [cnt_w-1:0] cnt;

   assign line_low = (phase == ph_low);   // reset pulse only

   always_ff @(posedge clk) begin
      if (rst) begin
         phase         <= ph_idle;
         cnt           <= '0;
         rif.done      <= 1'b0;
         rif.result    <= res_none;
         rif.rise_time <= 8'd0;
      end else begin
         rif.done <= 1'b0;
         case (phase)
            ph_idle: if (rif.start) begin
               phase         <= ph_low;
               cnt           <= '0;
               rif.result    <= res_none;
               rif.rise_time <= 8'd0;
            end
            ph_low: begin
               cnt <= cnt + 1'b1;
               if (cnt == low_end) begin
                  phase <= ph_rise;
                  cnt   <= '0;
               end
            end
            ph_rise: begin   // released, wait for the pull-up
               if (in) begin
                  rif.rise_time <= (cnt > cnt_w'(255)) ? 8'hFF : cnt[7:0];
                  phase         <= ph_wait;
                  cnt           <= '0;
               end else if (cnt == rise_max) begin
                  rif.result <= res_fail_rise;
                  rif.done   <= 1'b1;
                  phase      <= ph_idle;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ph_wait: begin
               cnt <= cnt + 1'b1;
               if (cnt == wait_end) begin
                  phase <= ph_presence;
                  cnt   <= '0;
               end
            end
            ph_presence: begin   // slave pulls low to answer
               if (!in) begin
                  rif.result <= res_ok;
                  phase      <= ph_recover;
                  cnt        <= '0;
               end else if (cnt == pres_max) begin
                  rif.result <= res_fail_presence;
                  rif.done   <= 1'b1;
                  phase      <= ph_idle;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ph_recover: if (in) begin   // high clocks in total, unbounded
               cnt <= cnt + 1'b1;
               if (cnt == rec_end) begin
                  rif.done <= 1'b1;
                  phase    <= ph_idle;
               end
            end
            default: phase <= ph_idle;
         endcase
      end
   end

   // every reset ends with a real outcome for the sequencer
   assert property (@(posedge clk) disable iff (rst) rif.done |-> rif.result != res_none)
      else $error("reset ctrl: done without a result");

endmodule

`default_nettype wire

// ==== src/ow_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module ow_sequencer (
   input  wire         clk,
   input  wire         rst,
   input  wire         ctrl_wen,
   input  wire  [31:0] ctrl_wdata,
   ow_byte_if.master   bif,
   ow_reset_if.master  rif,
   output logic        buf_we,
   output logic [7:0]  buf_byte,
   output logic [7:0]  buf_idx,
   output logic        busy,
   output logic        ow_enable,
   output logic [7:0]  family_code
);
   import ow_pkg::*;

   localparam logic [7:0] rom_last = 8'(rom_bytes - 1);
   localparam logic [7:0] blk_last = 8'(blk_bytes - 1);

   ow_state_e   state;
   ow_cmd_e     cmd;
   logic        pend;      // byte or reset outstanding
   logic [10:0] addr;      // eprom start address
   logic [7:0]  cnt;       // rom byte / block byte index

   assign cmd  = ow_cmd_e'(ctrl_wdata[1:0]);
   assign busy = (state != idle);

   // byte to send in the write states, reads otherwise
   always_comb begin
      bif.wr = 1'b1;
      case (state)
         rom_cmd: bif.tx_byte = cmd_read_rom;
         mem_cmd: bif.tx_byte = cmd_read_mem;
         addr_lo: bif.tx_byte = addr[7:0];
         addr_hi: bif.tx_byte = {5'd0, addr[10:8]};
         default: begin
            bif.tx_byte = 8'h00;
            bif.wr      = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= idle;
         pend        <= 1'b0;
         cnt         <= 8'd0;
         bif.start   <= 1'b0;
         rif.start   <= 1'b0;
         buf_we      <= 1'b0;
         ow_enable   <= 1'b0;
         family_code <= 8'd0;
      end else begin
         bif.start <= 1'b0;
         rif.start <= 1'b0;
         buf_we    <= 1'b0;
         case (state)
            idle: if (ctrl_wen) begin   // commands only taken here
               case (cmd)
                  ow_disable:       ow_enable <= 1'b0;
                  ow_pkg::ow_enable: ow_enable <= 1'b1;  // port shares the name
                  ow_start_read: begin
                     ow_enable <= 1'b1;
                     addr      <= ctrl_wdata[26:16];
                     state     <= reset;
                  end
                  ow_continue: begin
                     cnt   <= 8'd0;
                     state <= mem_read;
                  end
                  default: ;
               endcase
            end
            reset: begin
               if (!pend) begin
                  rif.start <= 1'b1;
                  pend      <= 1'b1;
               end else if (rif.done) begin
                  pend  <= 1'b0;
                  state <= (rif.result == res_ok) ? rom_cmd : idle;  // give up on failure
               end
            end
            default: begin   // one byte per visit
               if (!pend) begin
                  bif.start <= 1'b1;
                  pend      <= 1'b1;
               end else if (bif.done) begin
                  pend <= 1'b0;
                  case (state)
                     rom_cmd: begin
                        cnt   <= 8'd0;
                        state <= rom_read;
                     end
                     rom_read: begin
                        if (cnt == 8'd0)
                           family_code <= bif.rx_byte;  // first rom byte
                        cnt <= cnt + 8'd1;
                        if (cnt == rom_last)
                           state <= mem_cmd;
                     end
                     mem_cmd: state <= addr_lo;
                     addr_lo: state <= addr_hi;
                     addr_hi: begin
                        cnt   <= 8'd0;
                        state <= mem_read;
                     end
                     mem_read: begin
                        buf_we   <= 1'b1;
                        buf_byte <= bif.rx_byte;
                        buf_idx  <= cnt;
                        cnt      <= cnt + 8'd1;   // wraps to 0 for continue
                        if (cnt == blk_last)
                           state <= idle;
                     end
                     default: state <= idle;
                  endcase
               end
            end
         endcase
      end
   end

   // buffer writes come only from memory reads
   assert property (@(posedge clk) disable iff (rst) buf_we |-> $past(state) == mem_read)
      else $error("sequencer: buffer write outside mem_read");

endmodule

`default_nettype wire

// ==== src/ow_block_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

module ow_block_buf (
   input  wire        clk,
   input  wire        rst,
   input  wire        we,
   input  wire  [7:0] byte_in,
   input  wire  [7:0] idx,      // byte index in block
   input  wire  [5:0] raddr,    // quadlet read address
   output logic [31:0] rdata
);
   import ow_pkg::*;

   logic [31:0] mem [blk_quads];

   // shift in from the low end, first byte ends in 31:24
   always_ff @(posedge clk) begin
      if (we)
         mem[idx[7:2]] <= {mem[idx[7:2]][23:0], byte_in};
   end

   always_ff @(posedge clk) begin
      if (rst)
         rdata <= 32'd0;
      else
         rdata <= mem[raddr];   // one clock read latency
   end

endmodule

`default_nettype wire

// ==== src/ow_master_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ow_master_top #(
   parameter int clk_mhz = 49   // timing base, whole MHz
) (
   input  wire         clk,
   input  wire         rst,
   input  wire         ctrl_wen,
   input  wire  [31:0] ctrl_wdata,
   input  wire  [5:0]  blk_raddr,
   output logic [31:0] blk_rdata,
   output logic [31:0] status,
   input  wire         ow_in,
   output logic        ow_out,
   output logic        ow_dir,     // 1 = master drives
   output logic        ow_enable
);

   ow_byte_if  bif ();
   ow_reset_if rif ();

   logic       busy;
   logic       buf_we;
   logic [7:0] buf_byte;
   logic [7:0] buf_idx;
   logic [7:0] family_code;
   logic       bit_low;      // slot pulses
   logic       rst_low;      // reset pulse

   ow_sequencer u_seq (
      .clk(clk), .rst(rst), .ctrl_wen(ctrl_wen), .ctrl_wdata(ctrl_wdata),
      .bif(bif.master), .rif(rif.master),
      .buf_we(buf_we), .buf_byte(buf_byte), .buf_idx(buf_idx),
      .busy(busy), .ow_enable(ow_enable), .family_code(family_code)
   );

   ow_bit_engine #(.clk_mhz(clk_mhz)) u_bit (
      .clk(clk), .rst(rst), .in(ow_in), .bif(bif.slave), .line_low(bit_low)
   );

   ow_reset_ctrl #(.clk_mhz(clk_mhz)) u_rst (
      .clk(clk), .rst(rst), .in(ow_in), .rif(rif.slave), .line_low(rst_low)
   );

   ow_block_buf u_buf (
      .clk(clk), .rst(rst), .we(buf_we), .byte_in(buf_byte), .idx(buf_idx),
      .raddr(blk_raddr), .rdata(blk_rdata)
   );

   // open drain, only ever pull low
   assign ow_dir = bit_low | rst_low;
   assign ow_out = ~ow_dir;

   assign status = {family_code, rif.rise_time, 2'b00, busy, 10'd0, rif.result, ow_enable};

endmodule

`default_nettype wire

// ==== tests/ds2505_model.sv ====
`timescale 1ns/1ns
`default_nettype none

// behavioral ds2505 slave on a clocked time base, clk_mhz clocks per us
module ds2505_model #(
   parameter int clk_mhz = 2
) (
   input  wire  clk,
   input  wire  master_low,   // uut pulls the line
   input  wire  present,      // 0 = no device on the bus
   input  wire  stuck_low,    // line shorted to ground
   output logic line
);
   import ow_pkg::*;

   typedef enum logic [1:0] {m_cmd, m_rom, m_addr, m_mem} mode_e;

   localparam int rst_min  = 400 * clk_mhz;  // shorter lows are slots
   localparam int pres_dly = 40 * clk_mhz;
   localparam int pres_len = 120 * clk_mhz;
   localparam int smp_dly  = 30 * clk_mhz;   // write sample point
   localparam int rd_hold  = 30 * clk_mhz;   // hold for a read 0

   mode_e       mode = m_cmd;
   logic        line_q = 1'b1;
   logic [2:0]  nbits = 3'd0;    // bit inside current byte
   logic [7:0]  sh = 8'd0;       // written bits, lsb first
   logic [10:0] addr = 11'd0;
   logic        addr_n = 1'b0;   // 0 = low address byte next
   int          rom_idx = 0;
   int          low_cnt = 0;
   int          pres_cnt = 0;
   int          pull_cnt = 0;
   int          smp_cnt = 0;
   int          reset_count = 0; // resets answered
   int          wr_count = 0;
   logic [7:0]  wr_log [16];     // every byte written by the master

   assign line = !stuck_low && !master_low && !(present && pull_cnt != 0);

   function automatic logic [7:0] rom_byte(input int i);
      return (i == 0) ? family_ds2505 : 8'h30 + 8'(i);  // family, then serial
   endfunction

   always @(posedge clk) begin
      logic [7:0] rd_byte;
      logic [7:0] wr_byte;
      line_q <= line;
      if (pull_cnt != 0) pull_cnt <= pull_cnt - 1;
      if (smp_cnt != 0) smp_cnt <= smp_cnt - 1;
      if (pres_cnt != 0) begin
         pres_cnt <= pres_cnt - 1;
         if (pres_cnt == 1) pull_cnt <= pres_len;   // presence pulse
      end
      // falling edge from the master opens a slot
      if (present && !stuck_low && line_q && !line && pull_cnt == 0) begin
         if (mode == m_cmd || mode == m_addr) begin
            smp_cnt <= smp_dly;
         end else begin
            rd_byte = (mode == m_rom) ? rom_byte(rom_idx) : (addr[7:0] ^ 8'h5A);
            if (!rd_byte[nbits]) pull_cnt <= rd_hold;  // answer a 0
            nbits <= nbits + 3'd1;
            if (nbits == 3'd7) begin
               if (mode == m_rom) begin
                  rom_idx <= rom_idx + 1;
                  if (rom_idx == 7) mode <= m_cmd;   // rom done
               end else begin
                  addr <= addr + 11'd1;
               end
            end
         end
      end
      if (smp_cnt == 1) begin
         wr_byte = {line, sh[7:1]};
         sh      <= wr_byte;
         nbits   <= nbits + 3'd1;
         if (nbits == 3'd7) begin
            if (wr_count < 16) wr_log[wr_count] <= wr_byte;
            wr_count <= wr_count + 1;
            if (mode == m_cmd && wr_byte == cmd_read_rom) begin
               mode    <= m_rom;
               rom_idx <= 0;
            end else if (mode == m_cmd && wr_byte == cmd_read_mem) begin
               mode   <= m_addr;
               addr_n <= 1'b0;
            end else if (mode == m_addr && !addr_n) begin
               addr[7:0] <= wr_byte;
               addr_n    <= 1'b1;
            end else if (mode == m_addr) begin
               addr[10:8] <= wr_byte[2:0];
               mode       <= m_mem;   // data follows
            end
         end
      end
      // long low, answered on release
      if (stuck_low) begin
         low_cnt <= 0;
      end else if (!line) begin
         low_cnt <= low_cnt + 1;
      end else begin
         if (present && low_cnt > rst_min) begin
            reset_count <= reset_count + 1;
            mode        <= m_cmd;
            nbits       <= 3'd0;
            smp_cnt     <= 0;
            pull_cnt    <= 0;
            pres_cnt    <= pres_dly;
         end
         low_cnt <= 0;
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_ow_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ow_master;
   import ow_pkg::*;

   localparam int clk_mhz    = 2;
   localparam int short_wait = 4000;     // one failed reset
   localparam int long_wait  = 600000;   // full block read

   logic        clk = 1'b0;
   logic        rst;
   logic        ctrl_wen;
   logic [31:0] ctrl_wdata;
   logic [5:0]  blk_raddr;
   logic [31:0] blk_rdata;
   logic [31:0] status;
   logic        ow_in, ow_out, ow_dir, ow_en;
   logic        present, stuck_low;
   logic        busy;
   int          test_errs = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   assign busy = status[13];

   ow_master_top #(.clk_mhz(clk_mhz)) uut (
      .clk(clk), .rst(rst), .ctrl_wen(ctrl_wen), .ctrl_wdata(ctrl_wdata),
      .blk_raddr(blk_raddr), .blk_rdata(blk_rdata), .status(status),
      .ow_in(ow_in), .ow_out(ow_out), .ow_dir(ow_dir), .ow_enable(ow_en)
   );

   ds2505_model #(.clk_mhz(clk_mhz)) slave (
      .clk(clk), .master_low(ow_dir & ~ow_out), .present(present),
      .stuck_low(stuck_low), .line(ow_in)
   );

   always #10 clk = ~clk;   // 20 ns period

   // memory contents as served by the device
   function automatic logic [7:0] eprom_byte(input int a);
      return a[7:0] ^ 8'h5A;
   endfunction

   // first byte of a quadlet lands in 31:24
   function automatic logic [31:0] packed_quad(input int base, input int k);
      int a;
      a = base + 4 * k;
      return {eprom_byte(a), eprom_byte(a + 1), eprom_byte(a + 2), eprom_byte(a + 3)};
   endfunction

   task automatic check_cond(input logic ok, input string msg);
      assert (ok) else begin
         $display("Mismatch at %0t: %s", $time, msg);
         test_errs++;
      end
   endtask

   task automatic finish_test(input string name);
      if (test_errs == 0) begin
         tests_passed++;
         $display("PASS %s", name);
      end else begin
         tests_failed++;
         $display("FAIL %s (%0d errors)", name, test_errs);
      end
      test_errs = 0;
   endtask

   // entered and left 2 ns after a rising edge
   task automatic send_cmd(input ow_cmd_e op, input logic [10:0] addr);
      ctrl_wdata = {5'd0, addr, 14'd0, op};
      ctrl_wen   = 1'b1;
      @(posedge clk);
      #2;
      ctrl_wen = 1'b0;
   endtask

   task automatic wait_idle(input int max_cycles);
      int n;
      n = 0;
      while (busy && n < max_cycles) begin
         @(posedge clk);
         #2;
         n++;
      end
      if (busy) begin
         $display("Timeout: transaction still running after %0d cycles", max_cycles);
         test_errs++;
      end
   endtask

   task automatic read_quad(input logic [5:0] k, output logic [31:0] q);
      blk_raddr = k;
      @(posedge clk);   // registered read port
      #2;
      q = blk_rdata;
   endtask

   task automatic check_block(input int base);
      logic [31:0] got;
      logic [31:0] exp;
      for (int k = 0; k < blk_quads; k++) begin
         read_quad(6'(k), got);
         exp = packed_quad(base, k);
         check_cond(got == exp, $sformatf("quad %0d is %08h, expected %08h", k, got, exp));
      end
   endtask

   task automatic test_enable_disable();
      check_cond(status == 32'd0 && !ow_dir && !ow_en, "outputs not idle after reset");
      send_cmd(ow_enable, 11'd0);
      check_cond(ow_en && status[0], "enable command did not take the line");
      check_cond(!busy, "busy set by enable");
      send_cmd(ow_disable, 11'd0);
      check_cond(!ow_en && !status[0], "disable command did not release the line");
      check_cond(!busy, "busy set by disable");
      finish_test("enable_disable");
   endtask

   task automatic test_no_device();
      present = 1'b0;
      send_cmd(ow_start_read, 11'd0);
      check_cond(busy, "start read did not set busy");
      wait_idle(short_wait);
      check_cond(status[2:1] == res_fail_presence,
                 $sformatf("reset result %0d, expected presence failure", status[2:1]));
      check_cond(!busy && !ow_dir, "bus not released after failed reset");
      present = 1'b1;
      finish_test("no_device");
   endtask

   task automatic test_stuck_line();
      stuck_low = 1'b1;
      send_cmd(ow_start_read, 11'd0);
      wait_idle(short_wait);
      check_cond(status[2:1] == res_fail_rise,
                 $sformatf("reset result %0d, expected rise failure", status[2:1]));
      stuck_low = 1'b0;
      repeat (20) @(posedge clk);   // let the line settle high
      #2;
      finish_test("stuck_line");
   endtask

   task automatic test_full_read();
      logic [7:0] exp_wr [4];
      int rc;
      int wc;
      exp_wr = '{cmd_read_rom, cmd_read_mem, 8'h23, 8'h01};   // rom, mem, address
      rc = slave.reset_count;
      wc = slave.wr_count;
      send_cmd(ow_start_read, 11'h123);
      wait_idle(long_wait);
      check_cond(status[2:1] == res_ok, $sformatf("reset result %0d", status[2:1]));
      // model line goes high on the first clock after release
      check_cond(status[23:16] == 8'd0,
                 $sformatf("rise time %0d clocks, expected 0", status[23:16]));
      check_cond(status[31:24] == family_ds2505,
                 $sformatf("family code %02h, expected 0b", status[31:24]));
      check_cond(slave.reset_count == rc + 1, "device did not see exactly one reset");
      check_cond(slave.wr_count == wc + 4,
                 $sformatf("%0d bytes written, expected 4", slave.wr_count - wc));
      for (int i = 0; i < 4; i++)
         check_cond(slave.wr_log[wc + i] == exp_wr[i],
                    $sformatf("written byte %0d is %02h, expected %02h",
                              i, slave.wr_log[wc + i], exp_wr[i]));
      check_block(11'h123);
      finish_test("full_read");
   endtask

   task automatic test_continue();
      int rc;
      rc = slave.reset_count;
      send_cmd(ow_continue, 11'd0);
      check_cond(busy, "continue did not set busy");
      wait_idle(long_wait);
      check_cond(slave.reset_count == rc, "continue issued a reset");
      check_block(11'h223);
      finish_test("continue");
   endtask

   task automatic test_ignored_cmd();
      int rc;
      rc = slave.reset_count;
      send_cmd(ow_enable, 11'd0);   // line taken before the block
      send_cmd(ow_continue, 11'd0);
      repeat (100) @(posedge clk);   // well inside the first byte
      #2;
      check_cond(busy, "not busy during continue");
      send_cmd(ow_disable, 11'd0);        // must be dropped
      send_cmd(ow_start_read, 11'h000);   // must be dropped
      check_cond(ow_en, "disable taken while busy");
      wait_idle(long_wait);
      check_cond(slave.reset_count == rc, "command during busy started a reset");
      check_cond(ow_en && status[0], "enable changed by ignored command");
      check_block(11'h323);
      finish_test("ignored_cmd");
   endtask

   initial begin
      rst        = 1'b1;
      ctrl_wen   = 1'b0;
      ctrl_wdata = 32'd0;
      blk_raddr  = 6'd0;
      present    = 1'b1;
      stuck_low  = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;
      test_enable_disable();
      test_no_device();
      test_stuck_line();
      test_full_read();
      test_continue();
      test_ignored_cmd();
      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
src/ow_pkg.sv
src/ow_byte_if.sv
src/ow_reset_if.sv
src/ow_bit_engine.sv
src/ow_reset_ctrl.sv
src/ow_sequencer.sv
src/ow_block_buf.sv
src/ow_master_top.sv
tests/ds2505_model.sv
tests/tb_ow_master.sv
